// ==== include/rvc_consts.svh ====
`ifndef RVC_CONSTS_SVH
`define RVC_CONSTS_SVH

// instruction memory depth in 32-bit words
`define RVC_MEM_WORDS 256

// word address width, log2 of the depth
`define RVC_MEM_AW 8

// width of a byte address
`define RVC_XLEN 32

// byte address where fetch starts after reset
`define RVC_RESET_PC 32'h0000_0000

`endif

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // full 32-bit instruction
    typedef logic [31:0] inst_t;

    // one halfword of the instruction stream
    typedef logic [15:0] parcel_t;

    // major opcode field, bits 6:0
    typedef logic [6:0] opcode_t;

    // integer register index
    typedef logic [4:0] reg_idx_t;

    // registers with a fixed role in the compressed forms
    localparam reg_idx_t reg_zero = 5'd0;
    localparam reg_idx_t reg_ra   = 5'd1;
    localparam reg_idx_t reg_sp   = 5'd2;

    // rv32i major opcodes
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_lui    = 7'b0110111;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_system = 7'b1110011;

endpackage

// ==== hdl/fetch_pkg.sv ====
`include "rvc_consts.svh"

package fetch_pkg;

    // byte address of an instruction
    typedef logic [`RVC_XLEN-1:0] pc_t;

    // word address into the instruction memory
    typedef logic [`RVC_MEM_AW-1:0] mem_addr_t;

    // one memory word
    typedef logic [31:0] word_t;

    // parcel queue occupancy, 0 to 3
    typedef logic [1:0] q_cnt_t;

    // run: no read outstanding
    // wait_grant: request held until the arbiter grants it
    // wait_data: granted read, data comes back next
    typedef enum logic [1:0] {
        run,
        wait_grant,
        wait_data
    } fetch_state_t;

endpackage

// ==== hdl/inst_expander.sv ====
`timescale 1ns/1ns

module inst_expander (
    input  rv_isa_pkg::inst_t i_inst,
    output rv_isa_pkg::inst_t o_inst,
    output logic              o_is_illegal,
    output logic              o_is_compressed
);
    import rv_isa_pkg::*;

    parcel_t  p;
    reg_idx_t rd;
    reg_idx_t rs2;
    reg_idx_t rd_p;
    reg_idx_t rs1_p;

    assign p     = i_inst[15:0];
    assign rd    = p[11:7];
    assign rs2   = p[6:2];
    // 3-bit register fields map onto x8..x15
    assign rd_p  = {2'b01, p[4:2]};
    assign rs1_p = {2'b01, p[9:7]};

    always_comb begin
        // upper half kept out so a compressed result ignores the next parcel
        o_inst          = {16'h0000, p};
        o_is_illegal    = 1'b0;
        o_is_compressed = 1'b1;

        unique casez ({p[1:0], p[15:13]})
            // c.addi4spn, addi rd', x2, nzuimm
            5'b00_000: begin
                o_inst = {2'b00, p[10:7], p[12:11], p[5], p[6], 2'b00,
                          reg_sp, 3'b000, rd_p, op_imm};
                o_is_illegal = p[12:5] == 8'h00;
            end
            // c.lw
            5'b00_010:
                o_inst = {5'b0, p[5], p[12:10], p[6], 2'b00, rs1_p, 3'b010, rd_p, op_load};
            // c.sw, rs2' sits in the rd' slot
            5'b00_110:
                o_inst = {5'b0, p[5], p[12], rd_p, rs1_p, 3'b010,
                          p[11:10], p[6], 2'b00, op_store};
            // c.addi and c.nop
            5'b01_000:
                o_inst = {{6{p[12]}}, p[12], p[6:2], rd, 3'b000, rd, op_imm};
            // c.jal links to x1, c.j to x0
            5'b01_001,
            5'b01_101:
                o_inst = {p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3],
                          p[12], {8{p[12]}}, 4'b0000, ~p[15], op_jal};
            // c.li
            5'b01_010:
                o_inst = {{6{p[12]}}, p[12], p[6:2], reg_zero, 3'b000, rd, op_imm};
            5'b01_011: begin
                if (rd == reg_sp) begin
                    // c.addi16sp
                    o_inst = {{3{p[12]}}, p[4:3], p[5], p[2], p[6], 4'b0000,
                              reg_sp, 3'b000, reg_sp, op_imm};
                end else begin
                    // c.lui
                    o_inst = {{15{p[12]}}, p[6:2], rd, op_lui};
                end
                o_is_illegal = {p[12], p[6:2]} == 6'b0;
            end
            5'b01_100: begin
                case (p[11:10])
                    // c.srli and c.srai, shamt[5] must be zero on rv32
                    2'b00,
                    2'b01: begin
                        o_inst = {1'b0, p[10], 5'b0, p[6:2], rs1_p, 3'b101, rs1_p, op_imm};
                        o_is_illegal = p[12];
                    end
                    // c.andi
                    2'b10:
                        o_inst = {{6{p[12]}}, p[12], p[6:2], rs1_p, 3'b111, rs1_p, op_imm};
                    default: begin
                        case (p[6:5])
                            2'b00: o_inst = {7'b0100000, rd_p, rs1_p, 3'b000, rs1_p, op_reg};
                            2'b01: o_inst = {7'b0000000, rd_p, rs1_p, 3'b100, rs1_p, op_reg};
                            2'b10: o_inst = {7'b0000000, rd_p, rs1_p, 3'b110, rs1_p, op_reg};
                            default: o_inst = {7'b0000000, rd_p, rs1_p, 3'b111, rs1_p, op_reg};
                        endcase
                        // subw and addw slots only exist on rv64
                        o_is_illegal = p[12];
                    end
                endcase
            end
            // c.beqz and c.bnez, funct3 bit 0 comes from p[13]
            5'b01_110,
            5'b01_111:
                o_inst = {{4{p[12]}}, p[6:5], p[2], reg_zero, rs1_p, 2'b00, p[13],
                          p[11:10], p[4:3], p[12], op_branch};
            // c.slli
            5'b10_000: begin
                o_inst = {7'b0, p[6:2], rd, 3'b001, rd, op_imm};
                o_is_illegal = p[12];
            end
            // c.lwsp, rd of x0 is reserved
            5'b10_010: begin
                o_inst = {4'b0, p[3:2], p[12], p[6:4], 2'b00, reg_sp, 3'b010, rd, op_load};
                o_is_illegal = rd == reg_zero;
            end
            5'b10_100: begin
                if (!p[12]) begin
                    if (rs2 != reg_zero) begin
                        // c.mv
                        o_inst = {7'b0, rs2, reg_zero, 3'b000, rd, op_reg};
                    end else begin
                        // c.jr
                        o_inst = {12'h000, rd, 3'b000, reg_zero, op_jalr};
                        o_is_illegal = rd == reg_zero;
                    end
                end else if (rs2 != reg_zero) begin
                    // c.add
                    o_inst = {7'b0, rs2, rd, 3'b000, rd, op_reg};
                end else if (rd == reg_zero) begin
                    // c.ebreak
                    o_inst = {12'h001, reg_zero, 3'b000, reg_zero, op_system};
                end else begin
                    // c.jalr
                    o_inst = {12'h000, rd, 3'b000, reg_ra, op_jalr};
                end
            end
            // c.swsp
            5'b10_110:
                o_inst = {4'b0, p[8:7], p[12], rs2, reg_sp, 3'b010, p[11:9], 2'b00, op_store};
            // full-width instruction
            5'b11_???: begin
                o_inst          = i_inst;
                o_is_compressed = 1'b0;
            end
            // fp slots and reserved funct3 values
            default:
                o_is_illegal = 1'b1;
        endcase
    end

endmodule

// ==== hdl/inst_mem.sv ====
`timescale 1ns/1ns
`include "rvc_consts.svh"

module inst_mem (
    input  logic                 i_clk,
    input  logic                 i_we,
    input  fetch_pkg::mem_addr_t i_addr,
    input  fetch_pkg::word_t     i_wdata,
    output fetch_pkg::word_t     o_rdata
);
    import fetch_pkg::*;

    word_t mem [`RVC_MEM_WORDS];

    // single port, write and registered read share the address
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_load_we,
    input  fetch_pkg::mem_addr_t i_load_addr,
    input  fetch_pkg::word_t     i_load_data,
    input  logic                 i_rd_req,
    input  fetch_pkg::mem_addr_t i_rd_addr,
    output logic                 o_rd_gnt,
    output logic                 o_rd_valid,
    output fetch_pkg::word_t     o_rd_data,
    output logic                 o_mem_we,
    output fetch_pkg::mem_addr_t o_mem_addr,
    output fetch_pkg::word_t     o_mem_wdata,
    input  fetch_pkg::word_t     i_mem_rdata
);

    logic rd_pending;

    // loader always has priority, a read waits behind any write
    assign o_rd_gnt    = i_rd_req && !i_load_we;
    assign o_mem_we    = i_load_we;
    assign o_mem_addr  = i_load_we ? i_load_addr : i_rd_addr;
    assign o_mem_wdata = i_load_data;

    // read port output lines up with the cycle after the grant
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= o_rd_gnt;
        end
    end

    assign o_rd_valid = rd_pending;
    assign o_rd_data  = i_mem_rdata;

endmodule

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ns
`include "rvc_consts.svh"

module fetch_unit (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_redirect,
    input  fetch_pkg::pc_t       i_redirect_pc,
    input  logic                 i_stall,
    output logic                 o_rd_req,
    output fetch_pkg::mem_addr_t o_rd_addr,
    input  logic                 i_rd_gnt,
    input  logic                 i_rd_valid,
    input  fetch_pkg::word_t     i_rd_data,
    output rv_isa_pkg::inst_t    o_window,
    input  logic                 i_is_compressed,
    output logic                 o_inst_valid,
    output fetch_pkg::pc_t       o_pc
);
    import fetch_pkg::*;
    import rv_isa_pkg::*;

    localparam pc_t reset_pc = `RVC_RESET_PC;

    fetch_state_t state;
    pc_t          pc;
    mem_addr_t    fetch_waddr;
    parcel_t      q [3];
    parcel_t      q_next [3];
    parcel_t      in_first;
    q_cnt_t       cnt;
    q_cnt_t       cnt_shift;
    q_cnt_t       cnt_next;
    q_cnt_t       pop_n;
    logic         active;
    logic         epoch;
    logic         req_epoch;
    logic         drop_low;
    logic         rd_fire;
    logic         push;
    logic         accept;

    // fetch stays idle until the first redirect
    assign o_rd_req  = active && (state == wait_grant || (state == run && cnt <= 2'd1));
    assign o_rd_addr = fetch_waddr;
    assign rd_fire   = o_rd_req && i_rd_gnt;
    // data from before a redirect carries the old epoch
    assign push      = i_rd_valid && state == wait_data && req_epoch == epoch;

    assign o_window     = {q[1], q[0]};
    assign o_inst_valid = cnt >= 2'd2 || (cnt == 2'd1 && i_is_compressed);
    assign o_pc         = pc;
    assign accept       = o_inst_valid && !i_stall;
    assign pop_n        = !accept ? 2'd0 : (i_is_compressed ? 2'd1 : 2'd2);
    assign in_first     = drop_low ? i_rd_data[31:16] : i_rd_data[15:0];

    // pop from the head, then append the returned word behind what is left
    always_comb begin
        q_next = q;
        if (pop_n == 2'd1) begin
            q_next[0] = q[1];
            q_next[1] = q[2];
        end else if (pop_n == 2'd2) begin
            q_next[0] = q[2];
        end
        cnt_shift = cnt - pop_n;
        cnt_next  = cnt_shift;
        if (push) begin
            for (int i = 0; i < 3; i++) begin
                if (i == int'(cnt_shift)) begin
                    q_next[i] = in_first;
                end else if (!drop_low && i == int'(cnt_shift) + 1) begin
                    q_next[i] = i_rd_data[31:16];
                end
            end
            cnt_next = cnt_shift + (drop_low ? 2'd1 : 2'd2);
        end
    end

    always_ff @(posedge i_clk) begin
        q <= q_next;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= run;
            pc          <= reset_pc;
            fetch_waddr <= reset_pc[`RVC_MEM_AW+1:2];
            cnt         <= '0;
            active      <= 1'b0;
            epoch       <= 1'b0;
            req_epoch   <= 1'b0;
            drop_low    <= reset_pc[1];
        end else if (i_redirect) begin
            // a read granted in the same cycle still has to drain
            if (rd_fire) begin
                state <= wait_data;
            end else begin
                state <= run;
            end
            if (rd_fire) begin
                req_epoch <= epoch;
            end
            pc          <= {i_redirect_pc[`RVC_XLEN-1:1], 1'b0};
            fetch_waddr <= i_redirect_pc[`RVC_MEM_AW+1:2];
            cnt         <= '0;
            active      <= 1'b1;
            epoch       <= ~epoch;
            drop_low    <= i_redirect_pc[1];
        end else begin
            cnt <= cnt_next;
            if (accept) begin
                pc <= pc + (i_is_compressed ? pc_t'(2) : pc_t'(4));
            end
            if (rd_fire) begin
                fetch_waddr <= fetch_waddr + 1'b1;
                req_epoch   <= epoch;
            end
            if (push) begin
                drop_low <= 1'b0;
            end
            case (state)
                run: begin
                    if (rd_fire) begin
                        state <= wait_data;
                    end else if (o_rd_req) begin
                        state <= wait_grant;
                    end
                end
                wait_grant: begin
                    if (rd_fire) begin
                        state <= wait_data;
                    end
                end
                default: begin
                    if (i_rd_valid) begin
                        state <= run;
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/rvc_fetch_top.sv ====
`timescale 1ns/1ns

module rvc_fetch_top (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_load_we,
    input  fetch_pkg::mem_addr_t i_load_addr,
    input  fetch_pkg::word_t     i_load_data,
    input  logic                 i_redirect,
    input  fetch_pkg::pc_t       i_redirect_pc,
    input  logic                 i_stall,
    output logic                 o_inst_valid,
    output fetch_pkg::pc_t       o_pc,
    output rv_isa_pkg::inst_t    o_inst,
    output logic                 o_is_compressed,
    output logic                 o_is_illegal
);
    import fetch_pkg::*;
    import rv_isa_pkg::*;

    logic      rd_req;
    mem_addr_t rd_addr;
    logic      rd_gnt;
    logic      rd_valid;
    word_t     rd_data;
    logic      mem_we;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;
    inst_t     window;

    inst_mem u_inst_mem (
        .i_clk   (i_clk),
        .i_we    (mem_we),
        .i_addr  (mem_addr),
        .i_wdata (mem_wdata),
        .o_rdata (mem_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_rd_req    (rd_req),
        .i_rd_addr   (rd_addr),
        .o_rd_gnt    (rd_gnt),
        .o_rd_valid  (rd_valid),
        .o_rd_data   (rd_data),
        .o_mem_we    (mem_we),
        .o_mem_addr  (mem_addr),
        .o_mem_wdata (mem_wdata),
        .i_mem_rdata (mem_rdata)
    );

    // compressed flag also tells the fetch unit how many parcels to pop
    fetch_unit u_fetch_unit (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_redirect      (i_redirect),
        .i_redirect_pc   (i_redirect_pc),
        .i_stall         (i_stall),
        .o_rd_req        (rd_req),
        .o_rd_addr       (rd_addr),
        .i_rd_gnt        (rd_gnt),
        .i_rd_valid      (rd_valid),
        .i_rd_data       (rd_data),
        .o_window        (window),
        .i_is_compressed (o_is_compressed),
        .o_inst_valid    (o_inst_valid),
        .o_pc            (o_pc)
    );

    inst_expander u_inst_expander (
        .i_inst          (window),
        .o_inst          (o_inst),
        .o_is_illegal    (o_is_illegal),
        .o_is_compressed (o_is_compressed)
    );

endmodule

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int period_ns = 8
) (
    output logic o_clk
);

    // free running, starts low
    initial begin
        o_clk = 1'b0;
        forever begin
            #(period_ns / 2) o_clk = ~o_clk;
        end
    end

endmodule

// ==== verification/rvc_fetch_tb.sv ====
`timescale 1ns/1ns
`include "rvc_consts.svh"

module rvc_fetch_tb;
    import fetch_pkg::*;
    import rv_isa_pkg::*;

    localparam int prog_words   = 48;
    localparam int pad_words    = 4;
    localparam int total_words  = prog_words + pad_words;
    localparam int prog_parcels = 2 * prog_words;
    // up to three walks over the program, plus reset and load
    localparam int limit_cycles = 40 * prog_parcels * 3 + total_words + 40;

    localparam logic [6:0] opc_load  = 7'b0000011;
    localparam logic [6:0] opc_imm   = 7'b0010011;
    localparam logic [6:0] opc_lui   = 7'b0110111;
    localparam logic [6:0] opc_jalr  = 7'b1100111;

    logic        clk;
    logic        rst_n;
    logic        load_we;
    mem_addr_t   load_addr;
    word_t       load_data;
    logic        redirect;
    pc_t         redirect_pc;
    logic        stall;
    logic        inst_valid;
    pc_t         pc;
    inst_t       inst;
    logic        is_compressed;
    logic        is_illegal;

    logic [31:0] rng;
    logic [15:0] parcels [2 * total_words];
    int          mi;
    logic        held;
    pc_t         held_pc;
    inst_t       held_inst;
    logic        held_cmp;
    logic        held_ill;

    tb_clock_gen #(.period_ns(8)) u_clock_gen (.o_clk(clk));

    rvc_fetch_top DUT (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_load_we       (load_we),
        .i_load_addr     (load_addr),
        .i_load_data     (load_data),
        .i_redirect      (redirect),
        .i_redirect_pc   (redirect_pc),
        .i_stall         (stall),
        .o_inst_valid    (inst_valid),
        .o_pc            (pc),
        .o_inst          (inst),
        .o_is_compressed (is_compressed),
        .o_is_illegal    (is_illegal)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // rv32i field packing
    function automatic logic [31:0] itype(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [31:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] btype(input logic [31:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jtype(input logic [31:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // reference expansion, returns {illegal, instruction}
    function automatic logic [32:0] expand_ref(input logic [31:0] win);
        logic [15:0] p;
        logic [4:0]  rd;
        logic [4:0]  rs2;
        logic [4:0]  rdp;
        logic [4:0]  rs1p;
        logic [31:0] sext6;
        logic [31:0] imm;
        logic [31:0] res;
        logic        ill;
        p     = win[15:0];
        rd    = p[11:7];
        rs2   = p[6:2];
        rdp   = {2'b01, p[4:2]};
        rs1p  = {2'b01, p[9:7]};
        sext6 = {{26{p[12]}}, p[12], p[6:2]};
        res   = 32'h0;
        ill   = 1'b0;
        if (p[1:0] == 2'b11) begin
            return {1'b0, win};
        end
        case ({p[1:0], p[15:13]})
            5'b00_000: begin
                imm = {22'b0, p[10:7], p[12:11], p[5], p[6], 2'b00};
                res = itype(imm, 5'd2, 3'b000, rdp, opc_imm);
                ill = imm == 32'h0;
            end
            5'b00_010: res = itype({25'b0, p[5], p[12:10], p[6], 2'b00}, rs1p, 3'b010, rdp,
                                   opc_load);
            5'b00_110: res = stype({25'b0, p[5], p[12:10], p[6], 2'b00}, rdp, rs1p);
            5'b01_000: res = itype(sext6, rd, 3'b000, rd, opc_imm);
            5'b01_001,
            5'b01_101: begin
                imm = {{20{p[12]}}, p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3],
                       1'b0};
                res = jtype(imm, p[15] ? 5'd0 : 5'd1);
            end
            5'b01_010: res = itype(sext6, 5'd0, 3'b000, rd, opc_imm);
            5'b01_011: begin
                if (rd == 5'd2) begin
                    imm = {{22{p[12]}}, p[12], p[4:3], p[5], p[2], p[6], 4'b0000};
                    res = itype(imm, 5'd2, 3'b000, 5'd2, opc_imm);
                end else begin
                    res = {{14{p[12]}}, p[12], p[6:2], rd, opc_lui};
                end
                ill = {p[12], p[6:2]} == 6'd0;
            end
            5'b01_100: begin
                ill = p[12];
                case (p[11:10])
                    2'b00: res = itype({27'b0, p[6:2]}, rs1p, 3'b101, rs1p, opc_imm);
                    2'b01: res = itype({20'b0, 7'b0100000, p[6:2]}, rs1p, 3'b101, rs1p,
                                       opc_imm);
                    2'b10: begin
                        res = itype(sext6, rs1p, 3'b111, rs1p, opc_imm);
                        ill = 1'b0;
                    end
                    default: begin
                        case (p[6:5])
                            2'b00: res = rtype(7'b0100000, rdp, rs1p, 3'b000, rs1p);
                            2'b01: res = rtype(7'b0, rdp, rs1p, 3'b100, rs1p);
                            2'b10: res = rtype(7'b0, rdp, rs1p, 3'b110, rs1p);
                            default: res = rtype(7'b0, rdp, rs1p, 3'b111, rs1p);
                        endcase
                    end
                endcase
            end
            5'b01_110,
            5'b01_111: begin
                imm = {{23{p[12]}}, p[12], p[6:5], p[2], p[11:10], p[4:3], 1'b0};
                res = btype(imm, rs1p, {2'b00, p[13]});
            end
            5'b10_000: begin
                res = itype({27'b0, p[6:2]}, rd, 3'b001, rd, opc_imm);
                ill = p[12];
            end
            5'b10_010: begin
                res = itype({24'b0, p[3:2], p[12], p[6:4], 2'b00}, 5'd2, 3'b010, rd, opc_load);
                ill = rd == 5'd0;
            end
            5'b10_100: begin
                if (rs2 != 5'd0) begin
                    // c.mv adds to x0, c.add to rd
                    res = rtype(7'b0, rs2, p[12] ? rd : 5'd0, 3'b000, rd);
                end else if (!p[12]) begin
                    res = itype(32'h0, rd, 3'b000, 5'd0, opc_jalr);
                    ill = rd == 5'd0;
                end else if (rd == 5'd0) begin
                    res = 32'h0010_0073;
                end else begin
                    res = itype(32'h0, rd, 3'b000, 5'd1, opc_jalr);
                end
            end
            5'b10_110: res = stype({24'b0, p[8:7], p[12:9], 2'b00}, rs2, 5'd2);
            default: ill = 1'b1;
        endcase
        return {ill, res};
    endfunction

    // one legal parcel from any rv32c slot
    function automatic logic [15:0] legal_parcel();
        logic [31:0] r;
        logic [15:0] p;
        logic [3:0]  slot;
        r    = next_rand();
        p    = r[15:0];
        slot = 4'(next_rand() % 15);
        if (slot < 4'd3) begin
            p[1:0]   = 2'b00;
            p[15:13] = slot == 4'd0 ? 3'b000 : (slot == 4'd1 ? 3'b010 : 3'b110);
        end else if (slot < 4'd11) begin
            p[1:0]   = 2'b01;
            p[15:13] = 3'(slot - 4'd3);
        end else begin
            p[1:0]   = 2'b10;
            p[15:13] = {2'(slot - 4'd11), 1'b0};
        end
        case ({p[1:0], p[15:13]})
            5'b00_000: begin
                if (p[12:5] == 8'h00) begin
                    p[5] = 1'b1;
                end
            end
            5'b01_011: begin
                // half of these become c.addi16sp
                if (r[20]) begin
                    p[11:7] = 5'd2;
                end
                if ({p[12], p[6:2]} == 6'd0) begin
                    p[2] = 1'b1;
                end
            end
            5'b01_100: begin
                if (p[11:10] != 2'b10) begin
                    p[12] = 1'b0;
                end
            end
            5'b10_000: p[12] = 1'b0;
            5'b10_010: begin
                if (p[11:7] == 5'd0) begin
                    p[11:7] = 5'd1;
                end
            end
            5'b10_100: begin
                p[12] = r[20];
                if (r[22:21] == 2'b00) begin
                    // c.jr and c.jalr
                    p[6:2] = 5'd0;
                    if (p[11:7] == 5'd0) begin
                        p[11:7] = 5'd3;
                    end
                end else if (r[22:21] == 2'b01 && r[20]) begin
                    p = 16'h9002;
                end else if (p[6:2] == 5'd0) begin
                    p[2] = 1'b1;
                end
            end
            default: ;
        endcase
        return p;
    endfunction

    function automatic logic [15:0] illegal_parcel();
        logic [31:0] r;
        logic [15:0] p;
        r = next_rand();
        p = r[15:0];
        case (r[18:16])
            3'd0: p = {3'b000, 8'h00, p[4:2], 2'b00};
            3'd1: p = {r[20:19], 1'b1, p[12:2], 2'b00};
            3'd2: p = {3'b100, p[12:2], 2'b00};
            3'd3: p = {r[20:19], 1'b1, p[12:2], 2'b10};
            3'd4: p = {3'b100, 1'b1, 1'b0, p[10:2], 2'b01};
            3'd5: p = {3'b010, p[12], 5'd0, p[6:2], 2'b10};
            3'd6: p = 16'h8002;
            default: p = {3'b011, 1'b0, p[11:7], 5'd0, 2'b01};
        endcase
        return p;
    endfunction

    task automatic build_program();
        int          i;
        logic [31:0] r;
        logic [31:0] w;
        i = 0;
        while (i < prog_parcels) begin
            r = next_rand();
            if (r[3:0] < 4'd6 && i + 1 < prog_parcels) begin
                // full-width, straddles a word when i is odd
                w = next_rand() | 32'h3;
                parcels[i]     = w[15:0];
                parcels[i + 1] = w[31:16];
                i += 2;
            end else if (r[3:0] == 4'hf) begin
                parcels[i] = illegal_parcel();
                i += 1;
            end else begin
                parcels[i] = legal_parcel();
                i += 1;
            end
        end
        // c.nop padding keeps run-ahead fetch on known data
        for (int k = prog_parcels; k < 2 * total_words; k++) begin
            parcels[k] = 16'h0001;
        end
    endtask

    task automatic load_program();
        for (int a = 0; a < total_words; a++) begin
            @(negedge clk);
            load_we   = 1'b1;
            load_addr = mem_addr_t'(a);
            load_data = {parcels[2 * a + 1], parcels[2 * a]};
        end
        @(negedge clk);
        load_we = 1'b0;
    endtask

    // loader traffic while fetch runs
    task automatic drive_loader();
        logic [31:0] r;
        int          a;
        r       = next_rand();
        load_we = r[2:0] == 3'd0;
        if (r[3]) begin
            // same contents back into the program
            a         = int'(r[15:8]) % total_words;
            load_data = {parcels[2 * a + 1], parcels[2 * a]};
        end else begin
            a         = total_words + 4 + int'(r[15:8]) % (`RVC_MEM_WORDS - total_words - 4);
            load_data = next_rand();
        end
        load_addr = mem_addr_t'(a);
    endtask

    task automatic check_accepted();
        logic [31:0] win;
        logic [32:0] exp;
        logic        exp_cmp;
        win     = {parcels[mi + 1], parcels[mi]};
        exp     = expand_ref(win);
        exp_cmp = win[1:0] != 2'b11;
        compare_value(pc, 32'(2 * mi), "pc");
        compare_value(32'(is_compressed), 32'(exp_cmp), "compressed flag");
        compare_value(32'(is_illegal), 32'(exp[32]), "illegal flag");
        if (!exp[32]) begin
            compare_value(inst, exp[31:0], $sformatf("instruction at pc %h", pc));
        end
        mi += exp_cmp ? 1 : 2;
    endtask

    task automatic check_held();
        compare_value(32'(inst_valid), 32'd1, "valid under stall");
        compare_value(pc, held_pc, "pc under stall");
        compare_value(inst, held_inst, "instruction under stall");
        compare_value(32'(is_compressed), 32'(held_cmp), "compressed flag under stall");
        compare_value(32'(is_illegal), 32'(held_ill), "illegal flag under stall");
    endtask

    // outputs are sampled at the falling edge, before new inputs go out
    task automatic run_stream(input int max_count);
        int          taken;
        logic [31:0] r;
        logic        stall_now;
        taken = 0;
        while (mi < prog_parcels && taken < max_count) begin
            @(negedge clk);
            if (held) begin
                check_held();
            end
            r         = next_rand();
            stall_now = r[1:0] == 2'b00;
            stall     = stall_now;
            drive_loader();
            if (inst_valid && !stall_now) begin
                check_accepted();
                taken++;
            end
            held      = inst_valid && stall_now;
            held_pc   = pc;
            held_inst = inst;
            held_cmp  = is_compressed;
            held_ill  = is_illegal;
        end
    endtask

    task automatic redirect_to(input int parcel_idx);
        @(negedge clk);
        stall       = 1'b0;
        load_we     = 1'b0;
        redirect    = 1'b1;
        redirect_pc = pc_t'(2 * parcel_idx);
        mi          = parcel_idx;
        held        = 1'b0;
        @(negedge clk);
        redirect = 1'b0;
        // queue was just cleared
        compare_value(32'(inst_valid), 32'd0, "valid after redirect");
    endtask

    initial begin
        rng         = 32'd50;
        rst_n       = 1'b0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        stall       = 1'b0;
        held        = 1'b0;
        mi          = 0;
        build_program();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        compare_value(32'(inst_valid), 32'd0, "valid after reset");
        load_program();
        redirect_to(0);
        run_stream(prog_parcels);
        // start on the second halfword, then jump into the middle
        redirect_to(1);
        run_stream(20);
        redirect_to(int'(next_rand() % 32'(prog_parcels - 8)));
        run_stream(prog_parcels);
        @(negedge clk);
        stall   = 1'b1;
        load_we = 1'b0;
        repeat (4) @(negedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: fetch did not reach the end of the program in %0d cycles",
                 limit_cycles);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== files.f ====
+incdir+include
hdl/rv_isa_pkg.sv
hdl/fetch_pkg.sv
hdl/inst_expander.sv
hdl/inst_mem.sv
hdl/mem_arbiter.sv
hdl/fetch_unit.sv
hdl/rvc_fetch_top.sv
verification/tb_clock_gen.sv
verification/rvc_fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f \
    --top-module rvc_fetch_tb -o rvc_fetch_sim

out=$(./obj_dir/rvc_fetch_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "TESTBENCH PASSED"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
